//--- common/sat_macros.svh
`ifndef SAT_MACROS_SVH
`define SAT_MACROS_SVH

// Variable slots. Variable 0 is reserved, so 1 to SAT_VAR_MAX-1 are legal.
`define SAT_VAR_MAX 16

// Node slots in the clause queue.
`define CLQ_DEPTH 32

// Clause ids run from 0 to CLAUSE_MAX-1 and then wrap.
`define CLAUSE_MAX 16

`endif

//--- common/sat_lit_pkg.sv
package sat_lit_pkg;

`include "sat_macros.svh"

    // A signed literal has the sign bit on top and is two's complement when negative.
    typedef logic [$clog2(`SAT_VAR_MAX):0] lit_t;

    // The head-table index adds SAT_VAR_MAX to the variable number for the negative polarity.
    typedef logic [$clog2(`SAT_VAR_MAX):0] lit_idx_t;

    // Maps a signed literal to its head-table index.
    function automatic lit_idx_t lit_to_idx(input lit_t lit);
        logic                              neg;
        logic [$clog2(`SAT_VAR_MAX)-1:0]   mag;
        neg = lit[$clog2(`SAT_VAR_MAX)];
        if (neg) begin
            mag = ~lit[$clog2(`SAT_VAR_MAX)-1:0] + 1'b1; // Undo the two's complement.
        end else begin
            mag = lit[$clog2(`SAT_VAR_MAX)-1:0];
        end
        return {neg, mag};
    endfunction

endpackage

//--- common/clause_store_pkg.sv
package clause_store_pkg;

`include "sat_macros.svh"

    // Slot index into the node array.
    typedef logic [$clog2(`CLQ_DEPTH)-1:0] ptr_t;

    // Pointer to a node, or nothing when is_null is set.
    typedef struct packed {
        logic is_null;
        ptr_t ptr;
    } link_t;

    typedef logic [$clog2(`CLAUSE_MAX)-1:0] clause_id_t;

    // One occurrence of a literal and the link to its next older occurrence.
    typedef struct packed {
        clause_id_t clause_id;
        link_t      next;
    } node_t;

    // End of every occurrence list, and the reset value of every head.
    localparam link_t LINK_NULL = '{is_null: 1'b1, ptr: '0};

endpackage

//--- clause_queue/indexed_store.sv
`timescale 1ns/1ps

module indexed_store #(
    parameter type    entry_t     = logic [7:0],
    parameter int     ENTRIES     = 16,
    parameter entry_t RESET_VALUE = '0
)(
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       wr_en,
    input  logic [$clog2(ENTRIES)-1:0] wr_addr,
    input  entry_t                     wr_data,

    input  logic [$clog2(ENTRIES)-1:0] rd_addr,
    output entry_t                     rd_data,

    input  logic [$clog2(ENTRIES)-1:0] rd_addr_b,
    output entry_t                     rd_data_b
);
    entry_t mem [ENTRIES];

    assign rd_data   = mem[rd_addr];   // Reads see the array before this edge's write.
    assign rd_data_b = mem[rd_addr_b];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem[i] <= RESET_VALUE;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

//--- clause_queue/clause_queue.sv
`timescale 1ns/1ps

`include "sat_macros.svh"

module clause_queue
    import sat_lit_pkg::*, clause_store_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  lit_idx_t   push_idx,
    input  clause_id_t push_clause,
    input  logic       push,
    output logic       full,

    input  lit_idx_t   head_idx,
    output link_t      head_link,

    input  ptr_t       node_ptr,
    output node_t      node_data
);
    // One bit wider than a slot index so a full queue is visible.
    logic [$clog2(`CLQ_DEPTH):0] tail;

    logic  push_ok;
    link_t old_head;
    node_t new_node;
    link_t new_head;

    assign full    = (tail == `CLQ_DEPTH);
    assign push_ok = push && !full;

    // New node goes in front of the literal's current list.
    assign new_node = '{clause_id: push_clause, next: old_head};
    assign new_head = '{is_null: 1'b0, ptr: ptr_t'(tail)};

    always_ff @(posedge clk) begin
        if (rst_n) begin
            tail <= '0;
        end else if (push_ok) begin
            tail <= tail + 1'b1;
        end
    end

    indexed_store #(
        .entry_t     (node_t),
        .ENTRIES     (`CLQ_DEPTH),
        .RESET_VALUE ('0)
    ) node_store_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (push_ok),
        .wr_addr   (ptr_t'(tail)),
        .wr_data   (new_node),
        .rd_addr   (node_ptr),
        .rd_data   (node_data),
        .rd_addr_b ('0),
        .rd_data_b ()
    );

    // Port b reads the old head for linking while port a serves the walker.
    indexed_store #(
        .entry_t     (link_t),
        .ENTRIES     (2 * `SAT_VAR_MAX),
        .RESET_VALUE (LINK_NULL)
    ) head_store_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (push_ok),
        .wr_addr   (push_idx),
        .wr_data   (new_head),
        .rd_addr   (head_idx),
        .rd_data   (head_link),
        .rd_addr_b (push_idx),
        .rd_data_b (old_head)
    );

endmodule

//--- design/clause_loader.sv
`timescale 1ns/1ps

`include "sat_macros.svh"

module clause_loader
    import sat_lit_pkg::*, clause_store_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  lit_t       in_lit,
    input  logic       in_lit_valid,
    input  logic       in_clause_end,

    input  logic       full,
    output lit_idx_t   push_idx,
    output clause_id_t push_clause,
    output logic       push
);
    clause_id_t clause_id;

    // The push path is purely combinational, so a literal lands in the queue
    // at the same edge it is strobed.
    assign push_idx    = lit_to_idx(in_lit);
    assign push_clause = clause_id;
    assign push        = in_lit_valid && !full; // Dropped literals are simply lost.

    // The last literal of a clause still carries the old id; the count moves after it.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            clause_id <= '0;
        end else if (in_clause_end) begin
            if (clause_id == clause_id_t'(`CLAUSE_MAX - 1)) begin
                clause_id <= '0;
            end else begin
                clause_id <= clause_id + 1'b1;
            end
        end
    end

endmodule

//--- design/occurrence_walker.sv
`timescale 1ns/1ps

module occurrence_walker
    import sat_lit_pkg::*, clause_store_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  lit_t       query_lit,
    input  logic       query_start,

    output lit_idx_t   head_idx,
    input  link_t      head_link,

    output ptr_t       node_ptr,
    input  node_t      node_data,

    output clause_id_t occ_clause,
    output logic       occ_valid,
    output logic       query_done,
    output logic       busy
);
    logic     active;
    logic     use_head;    // First walk cycle takes the link from the head table.
    logic     start_ok;
    lit_idx_t query_idx;
    link_t    cur_link;
    link_t    cur;

    assign head_idx = query_idx;
    assign cur      = use_head ? head_link : cur_link;
    assign node_ptr = cur.ptr;

    assign occ_clause = node_data.clause_id;
    assign occ_valid  = active && !cur.is_null;
    assign query_done = active && cur.is_null;
    assign busy       = active && !cur.is_null; // Low again in the query_done cycle.

    assign start_ok = query_start && !busy;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            active   <= 1'b0;
            use_head <= 1'b0;
        end else begin
            use_head <= start_ok;
            if (start_ok) begin
                active <= 1'b1;
            end else if (query_done) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            query_idx <= lit_to_idx(query_lit);
        end
        cur_link <= node_data.next; // Only consumed while the walk continues.
    end

endmodule

//--- design/sat_occurrence_top.sv
`timescale 1ns/1ps

module sat_occurrence_top
    import sat_lit_pkg::*, clause_store_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  lit_t       in_lit,
    input  logic       in_lit_valid,
    input  logic       in_clause_end,

    input  lit_t       query_lit,
    input  logic       query_start,

    output clause_id_t occ_clause,
    output logic       occ_valid,
    output logic       query_done,
    output logic       busy,
    output logic       full
);
    lit_idx_t   push_idx;
    clause_id_t push_clause;
    logic       push;
    lit_idx_t   head_idx;
    link_t      head_link;
    ptr_t       node_ptr;
    node_t      node_data;

    clause_loader clause_loader_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_lit        (in_lit),
        .in_lit_valid  (in_lit_valid),
        .in_clause_end (in_clause_end),
        .full          (full),
        .push_idx      (push_idx),
        .push_clause   (push_clause),
        .push          (push)
    );

    clause_queue clause_queue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_idx    (push_idx),
        .push_clause (push_clause),
        .push        (push),
        .full        (full),
        .head_idx    (head_idx),
        .head_link   (head_link),
        .node_ptr    (node_ptr),
        .node_data   (node_data)
    );

    occurrence_walker occurrence_walker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .query_lit   (query_lit),
        .query_start (query_start),
        .head_idx    (head_idx),
        .head_link   (head_link),
        .node_ptr    (node_ptr),
        .node_data   (node_data),
        .occ_clause  (occ_clause),
        .occ_valid   (occ_valid),
        .query_done  (query_done),
        .busy        (busy)
    );

endmodule

//--- verification/tb_sat_occurrence.sv
`timescale 1ns/1ps

`include "sat_macros.svh"

module tb_sat_occurrence
    import sat_lit_pkg::*, clause_store_pkg::*;
();
    localparam int CLK_PERIOD = 100;
    localparam int N_LIT      = 2 * `SAT_VAR_MAX;
    // Pushes plus queries of the five tests, in order.
    localparam int OPS        = (0 + 4) + (31 + 30) + (8 + 2) + (40 + 30) + (6 + 1);
    localparam int WATCHDOG_CYCLES = OPS * (`CLQ_DEPTH + 2) + 200;

    logic       clk;
    logic       rst_n;
    lit_t       in_lit;
    logic       in_lit_valid;
    logic       in_clause_end;
    lit_t       query_lit;
    logic       query_start;
    clause_id_t occ_clause;
    logic       occ_valid;
    logic       query_done;
    logic       busy;
    logic       full;

    int model_occ [N_LIT][$]; // Clause ids per literal index with the most recent first.
    int model_tail;
    int model_clause;
    int error_count;
    int test_count;
    int failed_tests;
    int test_errors;
    int seed;

    sat_occurrence_top sat_occurrence_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_lit        (in_lit),
        .in_lit_valid  (in_lit_valid),
        .in_clause_end (in_clause_end),
        .query_lit     (query_lit),
        .query_start   (query_start),
        .occ_clause    (occ_clause),
        .occ_valid     (occ_valid),
        .query_done    (query_done),
        .busy          (busy),
        .full          (full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run timed out before all tests finished.");
        $display("** FAIL **");
        $finish;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    // Negative literals are the two's complement of the variable number.
    function automatic lit_t make_lit(input int v, input bit neg);
        return neg ? lit_t'(-v) : lit_t'(v);
    endfunction

    function automatic int lit_index(input int v, input bit neg);
        return neg ? v + `SAT_VAR_MAX : v;
    endfunction

    function automatic int random_var();
        return 1 + ($urandom % (`SAT_VAR_MAX - 1));
    endfunction

    task automatic apply_reset();
        @(negedge clk);
        rst_n         = 1'b1;
        in_lit        = '0;
        in_lit_valid  = 1'b0;
        in_clause_end = 1'b0;
        query_lit     = '0;
        query_start   = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b0;
        for (int i = 0; i < N_LIT; i++) begin
            model_occ[i].delete();
        end
        model_tail   = 0;
        model_clause = 0;
    endtask

    task automatic push_literal(input int v, input bit neg, input bit last);
        @(negedge clk);
        check_value(full, model_tail == `CLQ_DEPTH, "full against model tail");
        in_lit        = make_lit(v, neg);
        in_lit_valid  = 1'b1;
        in_clause_end = last;
        if (model_tail < `CLQ_DEPTH) begin
            model_occ[lit_index(v, neg)].push_front(model_clause);
            model_tail++;
        end
        if (last) begin
            model_clause = (model_clause + 1) % `CLAUSE_MAX; // Advances even when dropped.
        end
    endtask

    task automatic end_load();
        @(negedge clk);
        in_lit_valid  = 1'b0;
        in_clause_end = 1'b0;
    endtask

    task automatic load_random(input int total);
        int left;
        int len;
        left = total;
        while (left > 0) begin
            len = 1 + ($urandom % 4);
            if (len > left) begin
                len = left;
            end
            for (int i = 0; i < len; i++) begin
                push_literal(random_var(), $urandom % 2, i == len - 1);
            end
            left -= len;
        end
        end_load();
    endtask

    // Each clause holds +v and one literal of another variable.
    task automatic load_positive(input int v, input int clauses);
        int w;
        repeat (clauses) begin
            w = random_var();
            if (w == v) begin
                w = (v % (`SAT_VAR_MAX - 1)) + 1;
            end
            push_literal(v, 1'b0, 1'b0);
            push_literal(w, $urandom % 2, 1'b1);
        end
        end_load();
    endtask

    task automatic run_query(input int v, input bit neg, input int extra_at, output int count);
        int    got [$];
        int    idx;
        int    exp_len;
        int    cycles;
        bit    done;
        string tag;
        idx     = lit_index(v, neg);
        exp_len = model_occ[idx].size();
        tag     = $sformatf("query %s%0d", neg ? "-" : "+", v);
        @(negedge clk);
        query_lit   = make_lit(v, neg);
        query_start = 1'b1;
        cycles      = 0;
        done        = 1'b0;
        while (!done && cycles < `CLQ_DEPTH + 2) begin
            @(negedge clk);
            query_start = 1'b0;
            cycles++;
            if (cycles == extra_at) begin
                check_value(busy, 1'b1, {tag, " busy when second start is driven"});
                query_lit   = make_lit(v, !neg);
                query_start = 1'b1;
            end
            check_value(occ_valid, cycles <= exp_len, {tag, " occ_valid during walk"});
            check_value(query_done, cycles == exp_len + 1, {tag, " query_done during walk"});
            check_value(busy, cycles <= exp_len, {tag, " busy during walk"});
            if (occ_valid) begin
                got.push_back(occ_clause);
            end
            done = query_done;
        end
        query_start = 1'b0;
        check_value(done, 1'b1, {tag, " query_done seen"});
        check_value(cycles, exp_len + 1, {tag, " cycles to query_done"});
        check_value(got.size(), exp_len, {tag, " occurrence count"});
        for (int i = 0; i < got.size() && i < exp_len; i++) begin
            check_value(got[i], model_occ[idx][i], $sformatf("%s clause id %0d", tag, i));
        end
        repeat (2) begin
            @(negedge clk);
            check_value(occ_valid | query_done | busy, 1'b0, {tag, " quiet after query_done"});
        end
        count = got.size();
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count != test_errors) begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, name,
                     error_count - test_errors);
        end else begin
            $display("test %0d %s: passed", test_count, name);
        end
        test_errors = error_count;
    endtask

    initial begin
        int v;
        int count;
        rst_n         = 1'b1;
        in_lit        = '0;
        in_lit_valid  = 1'b0;
        in_clause_end = 1'b0;
        query_lit     = '0;
        query_start   = 1'b0;
        error_count   = 0;
        test_count    = 0;
        failed_tests  = 0;
        test_errors   = 0;
        seed          = 32041;
        void'($urandom(seed));

        apply_reset();
        @(negedge clk);
        check_value(occ_valid, 1'b0, "occ_valid after reset");
        check_value(query_done, 1'b0, "query_done after reset");
        check_value(busy, 1'b0, "busy after reset");
        check_value(full, 1'b0, "full after reset");
        repeat (4) run_query(random_var(), $urandom % 2, -1, count);
        finish_test("reset state");

        apply_reset();
        load_random(`CLQ_DEPTH - 1);
        for (int i = 1; i < `SAT_VAR_MAX; i++) begin
            run_query(i, 1'b0, -1, count);
            run_query(i, 1'b1, -1, count);
        end
        finish_test("random formula");

        apply_reset();
        v = random_var();
        load_positive(v, 4);
        run_query(v, 1'b1, -1, count);
        check_value(count, 0, "negative polarity occurrences");
        run_query(v, 1'b0, -1, count);
        check_value(count, 4, "positive polarity occurrences");
        finish_test("polarity separation");

        apply_reset();
        load_random(`CLQ_DEPTH + 8);
        check_value(full, 1'b1, "full after overflow");
        for (int i = 1; i < `SAT_VAR_MAX; i++) begin
            run_query(i, 1'b0, -1, count);
            run_query(i, 1'b1, -1, count);
        end
        check_value(sat_occurrence_top_inst.clause_loader_inst.clause_id, model_clause,
                    "clause id after dropped literals");
        finish_test("overflow");

        apply_reset();
        v = random_var();
        load_positive(v, 3);
        run_query(v, 1'b0, 2, count); // Second start lands in the middle of the walk.
        check_value(count, 3, "occurrences with a start while busy");
        finish_test("query while busy");

        $display("%0d tests run, %0d failed, %0d errors in total", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/sat_lit_pkg.sv
common/clause_store_pkg.sv
clause_queue/indexed_store.sv
clause_queue/clause_queue.sv
design/clause_loader.sv
design/occurrence_walker.sv
design/sat_occurrence_top.sv
verification/tb_sat_occurrence.sv
